// ==== source/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN = 32;
    localparam int REG_W = 5;

    // Tags travel at full width, the ROB uses only its low index bits
    localparam int TAG_MAX_W = 4;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // ALU view of the control nibble, op sits in bits 2..0
    typedef struct packed {
        logic    reserved;
        alu_op_e op;
    } alu_ctrl_t;

    // Multiply view of the same nibble, high_half is bit 0
    typedef struct packed {
        logic reserved;
        logic signed_b;
        logic signed_a;
        logic high_half;
    } mul_ctrl_t;

    // One control word, decoded by whichever unit takes the operation
    typedef union packed {
        alu_ctrl_t alu;
        mul_ctrl_t mul;
    } op_ctrl_u;

    // Wishbone write data for one issued operation
    typedef struct packed {
        unit_e              unit;
        logic [REG_W-1:0]   rd;
        op_ctrl_u           ctrl;
        logic [XLEN-1:0]    operand_a;
        logic [XLEN-1:0]    operand_b;
    } issue_word_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_MAX_W-1:0] tag;
        unit_e                unit;
        op_ctrl_u             ctrl;
        logic [XLEN-1:0]      operand_a;
        logic [XLEN-1:0]      operand_b;
    } dispatch_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_MAX_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } result_t;

    typedef struct packed {
        logic [TAG_MAX_W-1:0] tag;
        logic [REG_W-1:0]     rd;
        logic [XLEN-1:0]      value;
    } commit_t;

endpackage

// ==== source/alu_unit.sv ====
module alu_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  exec_pkg::dispatch_t  dispatch,
    output exec_pkg::result_t    result
);

    exec_pkg::alu_ctrl_t        ctrl;
    logic                       take;
    logic [exec_pkg::XLEN-1:0]  a;
    logic [exec_pkg::XLEN-1:0]  b;
    logic [4:0]                 shamt;
    logic [exec_pkg::XLEN-1:0]  alu_value;

    // Control nibble read as ALU control
    assign ctrl  = dispatch.ctrl.alu;
    assign take  = dispatch.valid && (dispatch.unit == exec_pkg::UNIT_ALU);
    assign a     = dispatch.operand_a;
    assign b     = dispatch.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.op)
            exec_pkg::ADD: alu_value = a + b;
            exec_pkg::SUB: alu_value = a - b;
            exec_pkg::AND: alu_value = a & b;
            exec_pkg::OR:  alu_value = a | b;
            exec_pkg::XOR: alu_value = a ^ b;
            exec_pkg::SLL: alu_value = a << shamt;
            exec_pkg::SRL: alu_value = a >> shamt;
            // Signed compare, result is 0 or 1
            exec_pkg::SLT: begin
                alu_value = {{(exec_pkg::XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            default: alu_value = '0;
        endcase
    end

    // One register stage, so the result shows one cycle after dispatch
    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= take;
        end
        if (take) begin
            result.tag   <= dispatch.tag;
            result.value <= alu_value;
        end
    end

endmodule

// ==== source/mul_unit.sv ====
module mul_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  exec_pkg::dispatch_t  dispatch,
    output exec_pkg::result_t    result
);

    // State carried down the multiply pipe
    typedef struct packed {
        logic                           valid;
        logic [exec_pkg::TAG_MAX_W-1:0] tag;
        logic                           high_half;
        logic [2*exec_pkg::XLEN-1:0]    product;
    } mul_stage_t;

    exec_pkg::mul_ctrl_t                ctrl;
    logic                               take;
    logic signed [exec_pkg::XLEN:0]     a_ext;
    logic signed [exec_pkg::XLEN:0]     b_ext;
    logic signed [2*exec_pkg::XLEN-1:0] full_product;
    mul_stage_t                         stage_in;
    mul_stage_t                         pipe [MUL_LATENCY];
    mul_stage_t                         last;

    // Same control nibble, read as multiply control
    assign ctrl = dispatch.ctrl.mul;
    assign take = dispatch.valid && (dispatch.unit == exec_pkg::UNIT_MUL);

    // 33 bit operands, top bit set only for a signed negative value
    assign a_ext = {ctrl.signed_a & dispatch.operand_a[exec_pkg::XLEN-1], dispatch.operand_a};
    assign b_ext = {ctrl.signed_b & dispatch.operand_b[exec_pkg::XLEN-1], dispatch.operand_b};

    // Low 64 bits of the extended product hold both halves
    assign full_product = (2*exec_pkg::XLEN)'(a_ext) * (2*exec_pkg::XLEN)'(b_ext);

    always_comb begin
        stage_in.valid     = take;
        stage_in.tag       = dispatch.tag;
        stage_in.high_half = ctrl.high_half;
        stage_in.product   = full_product;
    end

    // First stage takes the product, the rest just shift it along
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0] <= stage_in;
            for (int i = 1; i < MUL_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign last = pipe[MUL_LATENCY-1];

    // Half select after the final register
    always_comb begin
        result.valid = last.valid;
        result.tag   = last.tag;
        if (last.high_half) begin
            result.value = last.product[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
        end else begin
            result.value = last.product[exec_pkg::XLEN-1:0];
        end
    end

endmodule

// ==== source/reorder_buffer.sv ====
module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  exec_pkg::issue_word_t  wb_dat,
    input  exec_pkg::result_t      alu_result,
    input  exec_pkg::result_t      mul_result,
    output logic                   wb_ack,
    output exec_pkg::dispatch_t    dispatch,
    output logic                   commit_valid,
    output exec_pkg::commit_t      commit
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        logic                          busy;
        logic                          done;
        logic [exec_pkg::REG_W-1:0]    rd;
        logic [exec_pkg::XLEN-1:0]     value;
    } rob_entry_t;

    rob_entry_t                 entries [ROB_DEPTH];
    logic [IDX_W-1:0]           head;
    logic [IDX_W-1:0]           tail;
    logic [IDX_W:0]             count;

    logic                       full;
    logic                       accept;
    logic                       retire;
    logic                       alu_hits_head;
    logic                       mul_hits_head;
    logic [exec_pkg::XLEN-1:0]  head_value;

    assign full   = (count == (IDX_W+1)'(ROB_DEPTH));

    // Ack only every other cycle, and only with a free entry
    assign accept = wb_cyc && wb_stb && !wb_ack && !full;

    // A result for the head can retire it on the same edge it is written
    assign alu_hits_head = alu_result.valid && (alu_result.tag[IDX_W-1:0] == head);
    assign mul_hits_head = mul_result.valid && (mul_result.tag[IDX_W-1:0] == head);

    always_comb begin
        head_value = entries[head].value;
        if (alu_hits_head) begin
            head_value = alu_result.value;
        end else if (mul_hits_head) begin
            head_value = mul_result.value;
        end
    end

    assign retire = entries[head].busy &&
                    (entries[head].done || alu_hits_head || mul_hits_head);

    // Issue handshake and dispatch, registered together
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack         <= 1'b0;
            dispatch.valid <= 1'b0;
        end else begin
            wb_ack         <= accept;
            dispatch.valid <= accept;
        end
        if (accept) begin
            dispatch.tag       <= exec_pkg::TAG_MAX_W'(tail);
            dispatch.unit      <= wb_dat.unit;
            dispatch.ctrl      <= wb_dat.ctrl;
            dispatch.operand_a <= wb_dat.operand_a;
            dispatch.operand_b <= wb_dat.operand_b;
        end
    end

    // Entry table, pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                entries[tail].busy <= 1'b1;
                entries[tail].done <= 1'b0;
                entries[tail].rd   <= wb_dat.rd;
                tail               <= tail + 1'b1;
            end
            // Both paths may finish in one cycle, always on different tags
            if (alu_result.valid) begin
                entries[alu_result.tag[IDX_W-1:0]].done  <= 1'b1;
                entries[alu_result.tag[IDX_W-1:0]].value <= alu_result.value;
            end
            if (mul_result.valid) begin
                entries[mul_result.tag[IDX_W-1:0]].done  <= 1'b1;
                entries[mul_result.tag[IDX_W-1:0]].value <= mul_result.value;
            end
            // Retire last so it wins over a result landing on the head
            if (retire) begin
                entries[head].busy <= 1'b0;
                entries[head].done <= 1'b0;
                head               <= head + 1'b1;
            end
            count <= count + (IDX_W+1)'(accept) - (IDX_W+1)'(retire);
        end
    end

    // In-order commit record, at most one per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
        if (retire) begin
            commit.tag   <= exec_pkg::TAG_MAX_W'(head);
            commit.rd    <= entries[head].rd;
            commit.value <= head_value;
        end
    end

endmodule

// ==== source/exec_core.sv ====
module exec_core #(
    parameter int ROB_DEPTH   = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  exec_pkg::issue_word_t  wb_dat,
    output logic                   wb_ack,
    output logic                   commit_valid,
    output exec_pkg::commit_t      commit
);

    // One dispatch record feeds both paths
    exec_pkg::dispatch_t dispatch;
    exec_pkg::result_t   alu_result;
    exec_pkg::result_t   mul_result;

    reorder_buffer #(
        .ROB_DEPTH    (ROB_DEPTH)
    ) u_rob (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_dat       (wb_dat),
        .alu_result   (alu_result),
        .mul_result   (mul_result),
        .wb_ack       (wb_ack),
        .dispatch     (dispatch),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    alu_unit u_alu (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .result       (alu_result)
    );

    mul_unit #(
        .MUL_LATENCY  (MUL_LATENCY)
    ) u_mul (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .result       (mul_result)
    );

endmodule

// ==== tb/commit_monitor.sv ====
module commit_monitor (
    input  logic               clk,
    input  logic               commit_valid,
    input  exec_pkg::commit_t  commit,
    input  logic               exp_push,
    input  int                 exp_test,
    input  logic               exp_last,
    input  exec_pkg::commit_t  exp_commit,
    output int                 groups_passed,
    output int                 groups_failed,
    output int                 error_count,
    output int                 commits_seen
);

    typedef struct packed {
        int                 test;
        logic               last;
        exec_pkg::commit_t  rec;
    } expect_t;

    expect_t pending [$];
    expect_t incoming;
    expect_t want;
    int      group_errors = 0;
    int      group_commits = 0;

    initial begin
        groups_passed = 0;
        groups_failed = 0;
        error_count   = 0;
        commits_seen  = 0;
    end

    task automatic compare_field(input string name, input int test,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: group %0d commit %0d %s is %h, expected %h",
                     $time, test, commits_seen, name, got, exp);
            group_errors++;
            error_count++;
        end
    endtask

    // Sampled on the falling edge, away from the DUT's register updates
    always @(negedge clk) begin
        if (exp_push) begin
            incoming.test = exp_test;
            incoming.last = exp_last;
            incoming.rec  = exp_commit;
            pending.push_back(incoming);
        end
        if (commit_valid) begin
            commits_seen++;
            if (pending.size() == 0) begin
                $display("Commit with tag %0d at time %0t arrived with no operation outstanding",
                         commit.tag, $time);
                error_count++;
            end else begin
                want = pending.pop_front();
                group_commits++;
                compare_field("tag", want.test, 32'(commit.tag), 32'(want.rec.tag));
                compare_field("rd", want.test, 32'(commit.rd), 32'(want.rec.rd));
                compare_field("value", want.test, commit.value, want.rec.value);
                if (want.last) begin
                    if (group_errors == 0) begin
                        groups_passed++;
                        $display("group %0d: %0d commits in order, pass", want.test, group_commits);
                    end else begin
                        groups_failed++;
                        $display("group %0d: %0d commits, %0d wrong fields, fail",
                                 want.test, group_commits, group_errors);
                    end
                    group_errors  = 0;
                    group_commits = 0;
                end
            end
        end
    end

endmodule

// ==== tb/exec_core_checker.sv ====
module exec_core_checker #(
    parameter int ROB_DEPTH = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic wb_ack,
    input  logic commit_valid
);

    // Occupancy rebuilt from acknowledges and commits, lags the ROB by a cycle
    int occupancy;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(wb_ack) - int'(commit_valid);
        end
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for two consecutive cycles");

    // An acknowledge needs a free entry before its edge
    ack_not_full: assert property (@(posedge clk) disable iff (reset)
                                   wb_ack |-> (occupancy < ROB_DEPTH))
        else $error("wb_ack raised with all %0d entries busy", ROB_DEPTH);

    quiet_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
        else $error("commit_valid high in the cycle after reset");

endmodule

// ==== tb/tb_exec_core.sv ====
module tb_exec_core;

    localparam int ROB_DEPTH   = 8;
    localparam int MUL_LATENCY = 3;
    localparam int MAX_OPS     = 64;
    localparam string TRACE_FILE = "tb/exec_trace.txt";

    logic                   clk;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    exec_pkg::issue_word_t  wb_dat;
    logic                   wb_ack;
    logic                   commit_valid;
    exec_pkg::commit_t      commit;

    // Expected record handed to the monitor once per issue
    logic                   exp_push;
    int                     exp_test;
    logic                   exp_last;
    exec_pkg::commit_t      exp_commit;
    int                     groups_passed;
    int                     groups_failed;
    int                     error_count;
    int                     commits_seen;

    exec_pkg::issue_word_t  trace_word [MAX_OPS];
    logic [31:0]            trace_value [MAX_OPS];
    int                     trace_test [MAX_OPS];
    int                     trace_gap [MAX_OPS];
    logic                   trace_last [MAX_OPS];
    int                     n_ops = 0;
    int                     n_groups = 0;
    bit                     trace_loaded = 1'b0;
    bit                     load_ok;

    exec_core #(
        .ROB_DEPTH    (ROB_DEPTH),
        .MUL_LATENCY  (MUL_LATENCY)
    ) u_exec_core (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    commit_monitor u_monitor (
        .clk           (clk),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .exp_push      (exp_push),
        .exp_test      (exp_test),
        .exp_last      (exp_last),
        .exp_commit    (exp_commit),
        .groups_passed (groups_passed),
        .groups_failed (groups_failed),
        .error_count   (error_count),
        .commits_seen  (commits_seen)
    );

    bind exec_core exec_core_checker #(
        .ROB_DEPTH    (ROB_DEPTH)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .wb_ack       (wb_ack),
        .commit_valid (commit_valid)
    );

    always #5 clk = ~clk;

    // Trace columns are test, unit, ctrl, rd, operand_a, operand_b, value and gap
    task automatic load_trace(output bit ok);
        int          fd;
        int          fields;
        string       line;
        int          test;
        int          unit;
        int          ctrl;
        int          rd;
        int          gap;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        fd = $fopen(TRACE_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                fields = 0;
                if (line.substr(0, 0) != "#") begin
                    fields = $sscanf(line, "%d %d %h %d %h %h %h %d",
                                     test, unit, ctrl, rd, a, b, value, gap);
                end
                if (fields == 8 && n_ops < MAX_OPS) begin
                    trace_word[n_ops].unit      = (unit != 0) ? exec_pkg::UNIT_MUL
                                                              : exec_pkg::UNIT_ALU;
                    trace_word[n_ops].rd        = rd[4:0];
                    trace_word[n_ops].ctrl      = ctrl[3:0];
                    trace_word[n_ops].operand_a = a;
                    trace_word[n_ops].operand_b = b;
                    trace_value[n_ops]          = value;
                    trace_test[n_ops]           = test;
                    trace_gap[n_ops]            = gap;
                    n_ops++;
                end
            end
            $fclose(fd);
            // A group ends where the test number changes
            for (int i = 0; i < n_ops; i++) begin
                trace_last[i] = (i == n_ops - 1) || (trace_test[i + 1] != trace_test[i]);
                if (trace_last[i]) begin
                    n_groups++;
                end
            end
            ok = (n_ops > 0);
        end
    endtask

    // Called on a rising edge and returns on the edge after wb_ack
    task automatic issue_op(input int idx);
        exec_pkg::commit_t rec;
        rec.tag   = (exec_pkg::TAG_MAX_W)'(idx % ROB_DEPTH);
        rec.rd    = trace_word[idx].rd;
        rec.value = trace_value[idx];
        if (trace_gap[idx] > 0) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            repeat (trace_gap[idx]) @(posedge clk);
        end
        wb_cyc     <= 1'b1;
        wb_stb     <= 1'b1;
        wb_dat     <= trace_word[idx];
        exp_push   <= 1'b1;
        exp_test   <= trace_test[idx];
        exp_last   <= trace_last[idx];
        exp_commit <= rec;
        @(posedge clk);
        exp_push <= 1'b0;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(posedge clk);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_dat     = '0;
        exp_push   = 1'b0;
        exp_test   = 0;
        exp_last   = 1'b0;
        exp_commit = '0;
        load_trace(load_ok);
        if (!load_ok) begin
            $display("Could not read any operation from %s", TRACE_FILE);
            $display("Test FAILED");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            for (int i = 0; i < n_ops; i++) begin
                issue_op(i);
            end
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            while (commits_seen < n_ops) @(posedge clk);
            // Quiet tail so that a stray commit still shows up
            repeat (20) @(posedge clk);
            $display("Summary: %0d groups passed, %0d failed, %0d errors, %0d of %0d commits",
                     groups_passed, groups_failed, error_count, commits_seen, n_ops);
            if (groups_failed == 0 && error_count == 0 && commits_seen == n_ops &&
                groups_passed == n_groups) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    // Watchdog scaled to the trace length
    initial begin
        wait (trace_loaded);
        repeat (n_ops * 40 + 200) @(posedge clk);
        $display("Run did not finish within %0d cycles, %0d of %0d commits seen",
                 n_ops * 40 + 200, commits_seen, n_ops);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tb/exec_trace.txt ====
# test unit ctrl rd operand_a operand_b expected gap
# unit 0 is the ALU and 1 the multiplier, ctrl, operands and expected value in hex
1 0 0 1  ffffffff 00000002 00000001 3
1 0 1 2  00000003 00000005 fffffffe 0
1 0 2 3  f0f0ff00 0ff0f0f0 00f0f000 0
1 0 3 4  12340000 00005678 12345678 0
1 0 4 5  ffff0000 0f0f0f0f f0f00f0f 0
1 0 5 6  00000001 00000024 00000010 0
1 0 6 7  80000000 0000001f 00000001 0
1 0 7 8  ffffffff 00000001 00000001 0
1 0 7 9  00000001 ffffffff 00000000 1
2 1 0 10 fffffffe 00000003 fffffffa 2
2 1 1 11 fffffffe 00000003 00000002 0
2 1 2 12 fffffffe 00000003 fffffffa 0
2 1 3 13 fffffffe 00000003 ffffffff 0
2 1 4 14 00000003 fffffffe fffffffa 0
2 1 5 15 00000003 fffffffe ffffffff 0
2 1 6 16 fffffffe fffffffe 00000004 0
2 1 7 17 fffffffe fffffffe 00000000 0
2 1 1 18 fffffffe fffffffe fffffffc 0
2 1 3 19 fffffffe fffffffe fffffffe 0
3 1 0 20 0000ffff 00010001 ffffffff 2
3 0 0 21 00000001 00000001 00000002 0
3 0 1 22 00000010 00000001 0000000f 0
3 0 3 23 000000f0 0000000f 000000ff 0
3 0 4 24 aaaaaaaa 55555555 ffffffff 0
4 1 0 25 00000002 00000003 00000006 2
4 1 0 26 00000010 00000010 00000100 0
4 1 0 27 0000ffff 0000ffff fffe0001 0
4 1 1 28 0000ffff 0000ffff 00000000 0
4 1 0 29 80000000 00000002 00000000 0
4 1 1 30 80000000 00000002 00000001 0
4 1 3 31 80000000 00000002 ffffffff 0
4 1 6 1  ffffffff ffffffff 00000001 0
4 1 7 2  ffffffff ffffffff 00000000 0
4 1 1 3  ffffffff ffffffff fffffffe 0
4 1 0 4  00000009 00000009 00000051 0

// ==== sim.f ====
source/exec_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/reorder_buffer.sv
source/exec_core.sv
tb/commit_monitor.sv
tb/exec_core_checker.sv
tb/tb_exec_core.sv

// ==== Makefile ====
# Verilator simulation of the execution core testbench
TOP       ?= tb_exec_core
RTL_TOP   ?= exec_core
SEED      ?= 1
LOG       ?= sim.log
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RTL_SRCS  := source/exec_pkg.sv source/alu_unit.sv source/mul_unit.sv \
             source/reorder_buffer.sv source/exec_core.sv

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported a failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a verdict, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
